//--- src.f
+incdir+source
source/cpu_types_pkg.sv
source/mem_types_pkg.sv
source/alu.sv
source/register_file.sv
source/control_unit.sv
source/request_unit.sv
source/datapath.sv
verif/tb_cpu_model.sv
verif/tb_datapath.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the core and its testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -f src.f --top-module tb_datapath \
	--Mdir "$OBJ" -o sim_tb; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation passed"
exit 0

//--- verif/tb_datapath.sv
// testbench top for the single-cycle core
// random program, memories with random wait states, checks against the reference model
`include "cpu_settings.svh"

module tb_datapath;
	timeunit 1ns;
	timeprecision 1ps;
	import cpu_types_pkg::*;
	import mem_types_pkg::*;

	localparam int PROG_WORDS   = 64;
	localparam int DATA_WORDS   = 64;
	localparam int HALT_TIMEOUT = 4000;
	localparam int QUIET_CYCLES = 20;

	logic      CLK = 1'b0;
	logic      nRST = 1'b0;
	imem_req_t imem_req;
	imem_rsp_t imem_rsp = '0;
	dmem_req_t dmem_req;
	dmem_rsp_t dmem_rsp = '0;
	logic      halt;

	logic [`WORD_W-1:0] imem [PROG_WORDS];
	logic [`WORD_W-1:0] dmem_init [DATA_WORDS];
	logic [`WORD_W-1:0] dmem [DATA_WORDS];

	// wait cycles left for the pending request, -1 when idle
	int        iwait = -1;
	int        dwait = -1;
	dmem_req_t dheld;
	imem_req_t fetch_exp;
	dmem_req_t store_exp;
	int        fetch_count = 0;
	int        store_count = 0;

	// counters of the main sequence
	int fetch_errors = 0;
	int dreq_errors = 0;
	int halt_errors = 0;
	int other_errors = 0;
	// counters of the memory models
	int mem_fetch_errors = 0;
	int mem_dreq_errors = 0;
	int protocol_errors = 0;

	always #10 CLK = ~CLK;

	datapath i_dut (
		.CLK      (CLK),
		.nRST     (nRST),
		.imem_req (imem_req),
		.imem_rsp (imem_rsp),
		.dmem_req (dmem_req),
		.dmem_rsp (dmem_rsp),
		.halt     (halt)
	);

	tb_cpu_model i_model ();

	task automatic verify_iaddr(input imem_req_t got, input imem_req_t exp, inout int errors);
		if (got !== exp) begin
			$display("mismatch at %0t: imem_req got iren=%b iaddr=%h, expected iren=%b iaddr=%h",
				$time, got.iren, got.iaddr, exp.iren, exp.iaddr);
			errors++;
		end
	endtask

	task automatic compare_dmem_req(input string name, input dmem_req_t got,
		input dmem_req_t exp, inout int errors);
		if (got !== exp) begin
			$write("mismatch at %0t: %s got dren=%b dwen=%b daddr=%h dstore=%h,",
				$time, name, got.dren, got.dwen, got.daddr, got.dstore);
			$display(" expected dren=%b dwen=%b daddr=%h dstore=%h",
				exp.dren, exp.dwen, exp.daddr, exp.dstore);
			errors++;
		end
	endtask

	task automatic expect_halt(input logic got, input logic exp, inout int errors);
		if (got !== exp) begin
			$display("mismatch at %0t: halt got %b, expected %b", $time, got, exp);
			errors++;
		end
	endtask

	function automatic funct_t random_funct();
		case ($urandom_range(4, 0))
			0: return ADDU;
			1: return SUBU;
			2: return AND;
			3: return OR;
			default: return SLT;
		endcase
	endfunction

	// random program over r0..r7, forward branches only, HALT in the last word
	task automatic build_program();
		int          i;
		int          kind;
		int          span;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		logic [15:0] off;
		i = 0;
		while (i < PROG_WORDS - 1) begin
			rs   = 5'($urandom_range(7, 0));
			rt   = 5'($urandom_range(7, 0));
			rd   = 5'($urandom_range(7, 1));
			imm  = 16'($urandom());
			off  = 16'(4 * $urandom_range(15, 0));
			kind = $urandom_range(9, 0);
			// keep branch and jump targets close and inside the program
			span = PROG_WORDS - 2 - i;
			if (span > 3)
				span = 3;
			case (kind)
				0, 1: imem[i] = {RTYPE, rs, rt, rd, 5'd0, random_funct()};
				2: imem[i] = {ADDIU, rs, rd, imm};
				3: imem[i] = {ORI, rs, rd, imm};
				4: imem[i] = {LUI, 5'd0, rd, imm};
				5: begin
					// word address from r0 plus a small offset
					imem[i] = {LW, 5'd0, rd, off};
					// store the loaded register right away
					if (i + 1 < PROG_WORDS - 1) begin
						i++;
						imem[i] = {SW, 5'd0, rd, 16'(4 * $urandom_range(15, 0))};
					end
				end
				6: imem[i] = {SW, 5'd0, rt, off};
				7: imem[i] = {BEQ, rs, rt, 16'($urandom_range(span, 0))};
				8: imem[i] = {BNE, rs, rt, 16'($urandom_range(span, 0))};
				default: imem[i] = {J, 26'(i + 1 + $urandom_range(span, 0))};
			endcase
			i++;
		end
		imem[PROG_WORDS - 1] = {HALT, 26'd0};
	endtask

	// memory models, inputs change on the falling edge only
	always @(negedge CLK) begin
		if (!nRST) begin
			dmem = dmem_init;
		end else begin
			// instruction port, one-cycle ihit after 0 to 3 wait cycles
			if (imem_rsp.ihit) begin
				imem_rsp.ihit = 1'b0;
				iwait = -1;
			end else if (imem_req.iren) begin
				if (iwait < 0)
					iwait = $urandom_range(3, 0);
				if (iwait == 0) begin
					if (fetch_count < i_model.fetch_trace.size()) begin
						fetch_exp.iren  = 1'b1;
						fetch_exp.iaddr = i_model.fetch_trace[fetch_count];
						verify_iaddr(imem_req, fetch_exp, mem_fetch_errors);
					end else begin
						$display("fetch of %h at %0t runs past the end of the model trace",
							imem_req.iaddr, $time);
						protocol_errors++;
					end
					fetch_count++;
					imem_rsp.ihit  = 1'b1;
					imem_rsp.iload = imem[imem_req.iaddr[7:2]];
				end else begin
					iwait--;
				end
			end
			// data port
			if (dmem_rsp.dhit) begin
				dmem_rsp.dhit = 1'b0;
				dwait = -1;
				// request drops on the edge that takes the hit
				if (dmem_req.dren || dmem_req.dwen) begin
					$display("data request still high at %0t, the cycle after its hit", $time);
					protocol_errors++;
				end
			end else if (dmem_req.dren || dmem_req.dwen) begin
				if (dwait < 0) begin
					dwait = $urandom_range(3, 0);
					dheld = dmem_req;
				end else begin
					// address and data held while waiting
					compare_dmem_req("dmem_req", dmem_req, dheld, mem_dreq_errors);
				end
				if (dwait == 0) begin
					if (dmem_req.dwen) begin
						if (store_count < i_model.store_addr.size()) begin
							store_exp.dren   = 1'b0;
							store_exp.dwen   = 1'b1;
							store_exp.daddr  = i_model.store_addr[store_count];
							store_exp.dstore = i_model.store_data[store_count];
							compare_dmem_req("dmem_req", dmem_req, store_exp, mem_dreq_errors);
						end else begin
							$display("store at %0t has no counterpart in the model", $time);
							protocol_errors++;
						end
						store_count++;
						dmem[dmem_req.daddr[7:2]] = dmem_req.dstore;
					end else begin
						dmem_rsp.dload = dmem[dmem_req.daddr[7:2]];
					end
					dmem_rsp.dhit = 1'b1;
				end else begin
					dwait--;
				end
			end
		end
	end

	initial begin
		int        k;
		int        cycles;
		int        total;
		imem_req_t fetch_idle;
		dmem_req_t dreq_idle;
		void'($urandom(32'h6cf8_9b7c));
		build_program();
		for (k = 0; k < DATA_WORDS; k++)
			dmem_init[k] = 32'(k) * 32'h0102_0305 ^ 32'hc3a5_0f00;
		i_model.run(imem, dmem_init);

		// reset for 3 cycles, released on a falling edge
		repeat (3) @(negedge CLK);
		nRST = 1'b1;
		fetch_idle.iren  = 1'b0;
		fetch_idle.iaddr = `PC_INIT;
		verify_iaddr(imem_req, fetch_idle, fetch_errors);
		// address and store data are don't care while idle
		dreq_idle = dmem_req;
		dreq_idle.dren = 1'b0;
		dreq_idle.dwen = 1'b0;
		compare_dmem_req("dmem_req", dmem_req, dreq_idle, dreq_errors);
		expect_halt(halt, 1'b0, halt_errors);

		cycles = 0;
		while (!halt && cycles < HALT_TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!halt) begin
			$display("timeout: halt did not rise within %0d cycles", HALT_TIMEOUT);
			other_errors++;
		end else begin
			if (fetch_count != i_model.fetch_trace.size()) begin
				$display("mismatch at %0t: fetch count got %0d, expected %0d",
					$time, fetch_count, i_model.fetch_trace.size());
				other_errors++;
			end
			if (store_count != i_model.store_addr.size()) begin
				$display("mismatch at %0t: store count got %0d, expected %0d",
					$time, store_count, i_model.store_addr.size());
				other_errors++;
			end
			// pc stays on the HALT word, both ports silent
			fetch_idle.iaddr = i_model.fetch_trace[$];
			repeat (QUIET_CYCLES) begin
				@(negedge CLK);
				expect_halt(halt, 1'b1, halt_errors);
				verify_iaddr(imem_req, fetch_idle, fetch_errors);
				dreq_idle = dmem_req;
				dreq_idle.dren = 1'b0;
				dreq_idle.dwen = 1'b0;
				compare_dmem_req("dmem_req", dmem_req, dreq_idle, dreq_errors);
			end
		end

		total = fetch_errors + mem_fetch_errors + dreq_errors + mem_dreq_errors
			+ halt_errors + other_errors + protocol_errors;
		$display("errors: fetch %0d, data request %0d, halt %0d, other %0d",
			fetch_errors + mem_fetch_errors, dreq_errors + mem_dreq_errors,
			halt_errors, other_errors + protocol_errors);
		if (total == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- verif/tb_cpu_model.sv
// reference interpreter for the supported MIPS subset
// records the expected fetch addresses and the store list of one program run
`include "cpu_settings.svh"

module tb_cpu_model;
	timeunit 1ns;
	timeprecision 1ps;
	import cpu_types_pkg::*;

	// program and data memories are 64 words each
	localparam int WORDS = 64;

	logic [`WORD_W-1:0] fetch_trace [$];
	logic [`WORD_W-1:0] store_addr [$];
	logic [`WORD_W-1:0] store_data [$];

	task automatic run(input logic [`WORD_W-1:0] prog [WORDS],
		input logic [`WORD_W-1:0] data [WORDS]);
		logic [`WORD_W-1:0] regs [`REG_COUNT];
		logic [`WORD_W-1:0] mem [WORDS];
		logic [`WORD_W-1:0] pc;
		logic [`WORD_W-1:0] nxt;
		logic [`WORD_W-1:0] ins;
		logic [`WORD_W-1:0] a;
		logic [`WORD_W-1:0] b;
		logic [`WORD_W-1:0] sext;
		logic [`WORD_W-1:0] addr;
		logic [4:0]         rt;
		logic [4:0]         rd;
		logic               done;
		int                 steps;
		mem = data;
		regs = '{default: '0};
		fetch_trace.delete();
		store_addr.delete();
		store_data.delete();
		pc = `PC_INIT;
		done = 1'b0;
		steps = 0;
		// forward-only control flow, one pass over the program at most
		while (!done && steps <= WORDS) begin
			ins = prog[pc[7:2]];
			fetch_trace.push_back(pc);
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			rt = ins[20:16];
			rd = ins[15:11];
			sext = {{16{ins[15]}}, ins[15:0]};
			addr = a + sext;
			nxt = pc + 32'd4;
			case (opcode_t'(ins[31:26]))
				RTYPE: begin
					case (funct_t'(ins[5:0]))
						ADDU: regs[rd] = a + b;
						SUBU: regs[rd] = a - b;
						AND:  regs[rd] = a & b;
						OR:   regs[rd] = a | b;
						SLT:  regs[rd] = {31'd0, $signed(a) < $signed(b)};
						default: ;
					endcase
				end
				ADDIU: regs[rt] = a + sext;
				ORI:   regs[rt] = a | {16'h0000, ins[15:0]};
				LUI:   regs[rt] = {ins[15:0], 16'h0000};
				LW:    regs[rt] = mem[addr[7:2]];
				SW: begin
					mem[addr[7:2]] = b;
					store_addr.push_back(addr);
					store_data.push_back(b);
				end
				// branch target is relative to the next instruction
				BEQ: if (a == b) nxt = pc + 32'd4 + (sext << 2);
				BNE: if (a != b) nxt = pc + 32'd4 + (sext << 2);
				J:    nxt = {nxt[31:28], ins[25:0], 2'b00};
				HALT: done = 1'b1;
				default: ;
			endcase
			// r0 stays zero whatever was written
			regs[0] = '0;
			pc = nxt;
			steps++;
		end
	endtask

endmodule

//--- source/datapath.sv
// single-cycle core top level
// program counter, instruction register, immediates, write-back and next pc
`include "cpu_settings.svh"

module datapath (
	input  logic                     CLK,
	input  logic                     nRST,
	output mem_types_pkg::imem_req_t imem_req,
	input  mem_types_pkg::imem_rsp_t imem_rsp,
	output mem_types_pkg::dmem_req_t dmem_req,
	input  mem_types_pkg::dmem_rsp_t dmem_rsp,
	output logic                     halt
);
	import cpu_types_pkg::*;

	logic [`WORD_W-1:0] pc;
	logic [`WORD_W-1:0] pc_nxt;
	logic [`WORD_W-1:0] pc_plus4;
	logic [`WORD_W-1:0] ir;
	logic [`WORD_W-1:0] instr;
	ctrl_t              ctrl;
	logic               ihit;
	logic               dhit;
	logic               iren;
	logic               dren;
	logic               dwen;
	logic [`WORD_W-1:0] rdat1;
	logic [`WORD_W-1:0] rdat2;
	logic [`WORD_W-1:0] imm_sext;
	logic [`WORD_W-1:0] imm_ext;
	logic [`WORD_W-1:0] alu_b;
	logic [`WORD_W-1:0] alu_out;
	logic               zero;
	logic [`WORD_W-1:0] wdat;
	logic [4:0]         wsel;
	logic               complete;
	logic               take_branch;

	assign ihit = imem_rsp.ihit;
	assign dhit = dmem_rsp.dhit;

	// fetched word in the hit cycle, held copy during the data access
	assign instr = ihit ? imem_rsp.iload : ir;

	always_ff @(posedge CLK) begin
		if (ihit) begin
			ir <= imem_rsp.iload;
		end
	end

	control_unit i_control (
		.instr (instr),
		.ctrl  (ctrl)
	);

	request_unit i_request (
		.CLK      (CLK),
		.nRST     (nRST),
		.ihit     (ihit),
		.dhit     (dhit),
		.mem_dren (ctrl.dren),
		.mem_dwen (ctrl.dwen),
		.halt_in  (ctrl.halt),
		.dren     (dren),
		.dwen     (dwen),
		.iren     (iren),
		.halt     (halt)
	);

	// instruction ends on ihit, or on dhit for loads and stores
	assign complete = (ihit & ~ctrl.dren & ~ctrl.dwen) | dhit;

	// rs and rt read ports, rd or rt destination
	assign wsel = ctrl.regdst ? instr[15:11] : instr[20:16];
	assign wdat = ctrl.memtoreg ? dmem_rsp.dload : alu_out;

	register_file i_regs (
		.CLK   (CLK),
		.nRST  (nRST),
		.wen   (ctrl.regwen & complete),
		.wsel  (wsel),
		.rsel1 (instr[25:21]),
		.rsel2 (instr[20:16]),
		.wdat  (wdat),
		.rdat1 (rdat1),
		.rdat2 (rdat2)
	);

	assign imm_sext = {{(`WORD_W-16){instr[15]}}, instr[15:0]};
	assign imm_ext  = ctrl.zero_ext ? {{(`WORD_W-16){1'b0}}, instr[15:0]} : imm_sext;
	assign alu_b    = ctrl.alusrc ? imm_ext : rdat2;

	alu i_alu (
		.op     (ctrl.aluop),
		.a      (rdat1),
		.b      (alu_b),
		.result (alu_out),
		.zero   (zero)
	);

	// next pc
	assign pc_plus4    = pc + 32'd4;
	assign take_branch = (ctrl.beq & zero) | (ctrl.bne & ~zero);

	always_comb begin
		if (ctrl.jump) begin
			pc_nxt = {pc_plus4[31:28], instr[25:0], 2'b00};
		end else if (take_branch) begin
			pc_nxt = pc_plus4 + {imm_sext[29:0], 2'b00};
		end else begin
			pc_nxt = pc_plus4;
		end
	end

	// pc freezes on halt and while a hit is pending
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc <= `PC_INIT;
		end else if (complete && !ctrl.halt) begin
			pc <= pc_nxt;
		end
	end

	assign imem_req.iren  = iren;
	assign imem_req.iaddr = pc;

	// address from rs plus offset, store data from rt
	assign dmem_req.dren   = dren;
	assign dmem_req.dwen   = dwen;
	assign dmem_req.daddr  = alu_out;
	assign dmem_req.dstore = rdat2;

	// an outstanding data access keeps the pc in place
	assert property (@(posedge CLK) disable iff (!nRST)
		((dren || dwen) && !dhit) |=> $stable(pc))
		else $error("pc moved during data access");

endmodule

//--- source/request_unit.sv
// memory request registers
// data enables held until dhit, instruction enable and sticky halt
module request_unit (
	input  logic CLK,
	input  logic nRST,
	input  logic ihit,
	input  logic dhit,
	input  logic mem_dren,
	input  logic mem_dwen,
	input  logic halt_in,
	output logic dren,
	output logic dwen,
	output logic iren,
	output logic halt
);

	logic dren_nxt;
	logic dwen_nxt;
	logic halt_nxt;
	logic iren_reg;

	// halt is taken only from a fetched instruction
	assign halt_nxt = halt | (halt_in & ihit);

	// data write request
	always_comb begin
		dwen_nxt = dwen;
		if (halt) begin
			dwen_nxt = 1'b0;
		end else if (!mem_dwen) begin
			// current instruction does not store
			dwen_nxt = 1'b0;
		end else if (ihit) begin
			// store just fetched, raise request next cycle
			dwen_nxt = 1'b1;
		end else if (dhit) begin
			dwen_nxt = 1'b0;
		end
	end

	// data read request, same rule as the write side
	always_comb begin
		dren_nxt = dren;
		if (halt) begin
			dren_nxt = 1'b0;
		end else if (!mem_dren) begin
			dren_nxt = 1'b0;
		end else if (ihit) begin
			dren_nxt = 1'b1;
		end else if (dhit) begin
			dren_nxt = 1'b0;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			dren     <= 1'b0;
			dwen     <= 1'b0;
			iren_reg <= 1'b0;
			halt     <= 1'b0;
		end else begin
			dren     <= dren_nxt;
			dwen     <= dwen_nxt;
			// fetch stops on the same edge that latches halt
			iren_reg <= ~halt_nxt;
			halt     <= halt_nxt;
		end
	end

	// no refetch while a data access is outstanding
	assign iren = iren_reg & ~dren & ~dwen;

	// one data access at a time
	assert property (@(posedge CLK) disable iff (!nRST) !(dren && dwen))
		else $error("dren and dwen both high");

	// once halted the core stays silent on both ports
	assert property (@(posedge CLK) disable iff (!nRST)
		halt |=> (halt && !iren && !dren && !dwen))
		else $error("request after halt");

endmodule

//--- source/control_unit.sv
// instruction decoder
// maps opcode and function fields to the control struct
`include "cpu_settings.svh"

module control_unit (
	input  logic [`WORD_W-1:0]   instr,
	output cpu_types_pkg::ctrl_t ctrl
);
	import cpu_types_pkg::*;

	opcode_t opcode;
	funct_t  funct;

	assign opcode = opcode_t'(instr[31:26]);
	assign funct  = funct_t'(instr[5:0]);

	always_comb begin
		// default is a no-op with no side effect
		ctrl       = '0;
		ctrl.aluop = ALU_ADD;
		case (opcode)
			RTYPE: begin
				ctrl.regwen = 1'b1;
				ctrl.regdst = 1'b1;
				case (funct)
					ADDU: ctrl.aluop = ALU_ADD;
					SUBU: ctrl.aluop = ALU_SUB;
					AND:  ctrl.aluop = ALU_AND;
					OR:   ctrl.aluop = ALU_OR;
					SLT:  ctrl.aluop = ALU_SLT;
					// unsupported function, drop the write
					default: ctrl.regwen = 1'b0;
				endcase
			end
			ADDIU: begin
				ctrl.alusrc = 1'b1;
				ctrl.regwen = 1'b1;
			end
			ORI: begin
				ctrl.aluop    = ALU_OR;
				ctrl.alusrc   = 1'b1;
				ctrl.zero_ext = 1'b1;
				ctrl.regwen   = 1'b1;
			end
			LUI: begin
				// alu shifts the zero extended immediate up
				ctrl.aluop    = ALU_LUI;
				ctrl.alusrc   = 1'b1;
				ctrl.zero_ext = 1'b1;
				ctrl.regwen   = 1'b1;
			end
			LW: begin
				// address is rs plus signed offset
				ctrl.alusrc   = 1'b1;
				ctrl.regwen   = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.dren     = 1'b1;
			end
			SW: begin
				ctrl.alusrc = 1'b1;
				ctrl.dwen   = 1'b1;
			end
			BEQ: begin
				// compare by subtraction, zero flag decides
				ctrl.aluop = ALU_SUB;
				ctrl.beq   = 1'b1;
			end
			BNE: begin
				ctrl.aluop = ALU_SUB;
				ctrl.bne   = 1'b1;
			end
			J:    ctrl.jump = 1'b1;
			HALT: ctrl.halt = 1'b1;
			default: ;
		endcase
	end

endmodule

//--- source/register_file.sv
// general purpose register file
// two combinational read ports, one synchronous write port, r0 fixed at zero
`include "cpu_settings.svh"

module register_file (
	input  logic               CLK,
	input  logic               nRST,
	input  logic               wen,
	input  logic [4:0]         wsel,
	input  logic [4:0]         rsel1,
	input  logic [4:0]         rsel2,
	input  logic [`WORD_W-1:0] wdat,
	output logic [`WORD_W-1:0] rdat1,
	output logic [`WORD_W-1:0] rdat2
);

	logic [`WORD_W-1:0] regs [`REG_COUNT];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			regs <= '{default: '0};
		end else if (wen && (wsel != '0)) begin
			// writes to r0 are discarded
			regs[wsel] <= wdat;
		end
	end

	assign rdat1 = regs[rsel1];
	assign rdat2 = regs[rsel2];

	// r0 must read zero whatever was written to it before
	assert property (@(posedge CLK) disable iff (!nRST) (rsel1 == '0) |-> (rdat1 == '0))
		else $error("r0 reads nonzero");

endmodule

//--- source/alu.sv
// arithmetic and logic unit
// add, subtract, and, or, signed compare, upper immediate, zero flag
`include "cpu_settings.svh"

module alu (
	input  cpu_types_pkg::aluop_t op,
	input  logic [`WORD_W-1:0]    a,
	input  logic [`WORD_W-1:0]    b,
	output logic [`WORD_W-1:0]    result,
	output logic                  zero
);
	import cpu_types_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			// signed compare, result is 0 or 1
			ALU_SLT: result = {{(`WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
			// immediate into the upper half
			ALU_LUI: result = b << 16;
			default: result = '0;
		endcase
	end

	// used by beq and bne
	assign zero = (result == '0);

endmodule

//--- source/mem_types_pkg.sv
// memory port types
// request and response structs for the instruction and data ports
`include "cpu_settings.svh"

package mem_types_pkg;

	// instruction port, core to memory
	typedef struct packed {
		logic               iren;
		logic [`WORD_W-1:0] iaddr;
	} imem_req_t;

	// instruction port, memory to core
	typedef struct packed {
		logic               ihit;
		logic [`WORD_W-1:0] iload;
	} imem_rsp_t;

	// data port, core to memory
	typedef struct packed {
		logic               dren;
		logic               dwen;
		logic [`WORD_W-1:0] daddr;
		logic [`WORD_W-1:0] dstore;
	} dmem_req_t;

	// data port, memory to core
	typedef struct packed {
		logic               dhit;
		logic [`WORD_W-1:0] dload;
	} dmem_rsp_t;

endpackage

//--- source/cpu_types_pkg.sv
// instruction encodings of the supported MIPS subset
// opcode, function code and ALU operation enums plus the decoded control struct
package cpu_types_pkg;

	// major opcodes, instr[31:26]
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDIU = 6'h09,
		ORI   = 6'h0d,
		LUI   = 6'h0f,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = 6'h3f
	} opcode_t;

	// r-type function codes, instr[5:0]
	typedef enum logic [5:0] {
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		SLT  = 6'h2a
	} funct_t;

	// alu operations
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4,
		ALU_LUI = 3'd5
	} aluop_t;

	// decoded control for one instruction
	typedef struct packed {
		aluop_t aluop;
		// b operand from immediate instead of rt
		logic   alusrc;
		// zero extend immediate, sign extend otherwise
		logic   zero_ext;
		logic   regwen;
		// write rd when set, rt otherwise
		logic   regdst;
		// write back load data instead of alu result
		logic   memtoreg;
		logic   dren;
		logic   dwen;
		logic   beq;
		logic   bne;
		logic   jump;
		logic   halt;
	} ctrl_t;

endpackage

//--- source/cpu_settings.svh
// core-wide sizing defines
// word width, register count and program counter reset address
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and address width in bits
`define WORD_W 32

// architectural register count
`define REG_COUNT 32

// first fetch address after reset
`define PC_INIT 32'h0000_0000

`endif
